//--- Makefile
# Verilator build for the smoothing channel

RTL = filt_pkg.sv ctrl_pkg.sv sample_window.sv avg_engine.sv smooth_ctrl.sv smooth_top.sv

.PHONY: all lint sim clean

all: sim

# RTL only, all warnings on
lint:
	verilator --lint-only -Wall +incdir+. --top-module smooth_top $(RTL)

# exit status follows the testbench result
sim:
	verilator --binary --timing -j 0 -f all.f --top-module tb_smooth -o tb_smooth
	./obj_dir/tb_smooth

clean:
	rm -rf obj_dir

//--- all.f
+incdir+.
filt_pkg.sv
ctrl_pkg.sv
sample_window.sv
avg_engine.sv
smooth_ctrl.sv
smooth_top.sv
tb_smooth.sv

//--- avg_engine.sv
// moving average engine
`timescale 1ns/1ps
`include "filt_config.svh"

module avg_engine (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                window_valid,
	input  filt_pkg::sample_t   taps [`WIN_DEPTH],
	input  filt_pkg::fill_t     fill,
	input  filt_pkg::avg_mode_e mode,
	output logic                out_valid,
	output filt_pkg::sample_t   avg_out,
	output logic                settled
);
	import filt_pkg::*;

	// number of newest taps that a mode adds up
	function automatic fill_t mode_len(input avg_mode_e m);
		case (m)
			AVG2:    mode_len = fill_t'(2);
			AVG3:    mode_len = fill_t'(3);
			AVG4:    mode_len = fill_t'(4);
			AVG8:    mode_len = fill_t'(8);
			default: mode_len = fill_t'(16);
		endcase
	endfunction

	// current window length
	fill_t     cur_len;

	// combinational sum of the selected taps
	sum_t      tap_sum;

	// stage one registers
	logic      s1_valid;
	sum_t      s1_sum;
	avg_mode_e s1_mode;
	logic      s1_full;

	// stage two scaled sum, before narrowing
	sum_t      scaled;

	assign cur_len = mode_len(mode);

	// add taps 0 .. len-1
	// sample_t to sum_t cast sign-extends
	always_comb begin
		tap_sum = '0;
		for (int i = 0; i < `WIN_DEPTH; i++) begin
			if (fill_t'(i) < cur_len) begin
				tap_sum = tap_sum + sum_t'(taps[i]);
			end
		end
	end

	// stage one valid
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= window_valid;
		end
	end

	// sum travels with its own mode
	// a later mode change cannot rescale it
	always_ff @(posedge clk) begin
		if (window_valid) begin
			s1_sum  <= tap_sum;
			s1_mode <= mode;
			// enough real samples behind this result
			s1_full <= (fill >= cur_len);
		end
	end

	// scale by the carried mode
	// arithmetic shift floors, the divide truncates toward zero
	always_comb begin
		case (s1_mode)
			AVG2:    scaled = s1_sum >>> 1;
			AVG3:    scaled = s1_sum / sum_t'(3);
			AVG4:    scaled = s1_sum >>> 2;
			AVG8:    scaled = s1_sum >>> 3;
			default: scaled = s1_sum >>> 4;
		endcase
	end

	// output strobe and settled flag
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			settled   <= 1'b0;
		end else begin
			out_valid <= s1_valid;
			if (s1_valid) begin
				settled <= s1_full;
			end
		end
	end

	// averaged value always fits a sample
	always_ff @(posedge clk) begin
		if (s1_valid) begin
			avg_out <= sample_t'(scaled);
		end
	end

endmodule

//--- ctrl_pkg.sv
// command port types
`include "filt_config.svh"

package ctrl_pkg;

	// opcode on the command port
	// code 3 is unused and behaves as a nop
	typedef enum logic [1:0] {
		CMD_NOP      = 2'd0,
		CMD_SET_MODE = 2'd1,
		CMD_CLEAR    = 2'd2
	} cmd_op_e;

	// raw mode code for set-mode, 4 to 7 all mean sixteen taps
	typedef logic [2:0] cmd_arg_t;

endpackage

//--- filt_config.svh
// smoothing filter sizes
`ifndef FILT_CONFIG_SVH
`define FILT_CONFIG_SVH

// signed input and output sample width
`define SAMPLE_W 16

// taps held in the window, longest average
`define WIN_DEPTH 16

// room for sixteen full-scale samples
`define SUM_W 20

// fill counter, 0 to WIN_DEPTH inclusive
`define FILL_W 5

`endif

//--- filt_pkg.sv
// filter datapath types
`include "filt_config.svh"

package filt_pkg;

	// one signed sample, also the averaged result
	typedef logic signed [`SAMPLE_W-1:0] sample_t;

	// accumulator for the selected taps
	typedef logic signed [`SUM_W-1:0] sum_t;

	// samples taken since the last flush, saturating
	typedef logic [`FILL_W-1:0] fill_t;

	// window length select
	// codes follow the command argument encoding
	typedef enum logic [2:0] {
		AVG2  = 3'd0,
		AVG3  = 3'd1,
		AVG4  = 3'd2,
		AVG8  = 3'd3,
		AVG16 = 3'd4
	} avg_mode_e;

endpackage

//--- sample_window.sv
// sample tap line
`timescale 1ns/1ps
`include "filt_config.svh"

module sample_window (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              sample_valid,
	input  filt_pkg::sample_t sample,
	input  logic              flush,
	output filt_pkg::sample_t taps [`WIN_DEPTH],
	output filt_pkg::fill_t   fill,
	output logic              window_valid
);
	import filt_pkg::*;

	// fill stops counting once the whole window is loaded
	localparam fill_t FILL_MAX = fill_t'(`WIN_DEPTH);

	// tap 0 holds the newest sample
	// shift only on a strobe, flush wins over a same-edge sample
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `WIN_DEPTH; i++) begin
				taps[i] <= '0;
			end
		end else if (flush) begin
			// flushed taps read as zero in every average
			for (int i = 0; i < `WIN_DEPTH; i++) begin
				taps[i] <= '0;
			end
		end else if (sample_valid) begin
			taps[0] <= sample;
			for (int i = 1; i < `WIN_DEPTH; i++) begin
				taps[i] <= taps[i-1];
			end
		end
	end

	// samples since last flush
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fill <= '0;
		end else if (flush) begin
			fill <= '0;
		end else if (sample_valid && (fill != FILL_MAX)) begin
			fill <= fill + fill_t'(1);
		end
	end

	// one pulse per accepted shift
	// a sample dropped by flush gives no pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			window_valid <= 1'b0;
		end else begin
			window_valid <= sample_valid && !flush;
		end
	end

endmodule

//--- smooth_ctrl.sv
// smoothing command decoder
`timescale 1ns/1ps

module smooth_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                cmd_valid,
	input  ctrl_pkg::cmd_op_e   cmd_op,
	input  ctrl_pkg::cmd_arg_t  cmd_arg,
	output filt_pkg::avg_mode_e mode,
	output logic                flush
);
	import filt_pkg::*;
	import ctrl_pkg::*;

	// raw argument code to window mode
	// codes 4 and up all pick sixteen taps
	function automatic avg_mode_e arg_to_mode(input cmd_arg_t arg);
		case (arg)
			3'd0:    arg_to_mode = AVG2;
			3'd1:    arg_to_mode = AVG3;
			3'd2:    arg_to_mode = AVG4;
			3'd3:    arg_to_mode = AVG8;
			default: arg_to_mode = AVG16;
		endcase
	endfunction

	// mode register plus a one-cycle flush pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode  <= AVG2;
			flush <= 1'b0;
		end else begin
			// flush lasts one cycle unless re-armed
			flush <= 1'b0;
			if (cmd_valid) begin
				case (cmd_op)
					CMD_SET_MODE: begin
						// new length, so old history is dropped
						mode  <= arg_to_mode(cmd_arg);
						flush <= 1'b1;
					end
					CMD_CLEAR: begin
						// history only, mode kept
						flush <= 1'b1;
					end
					default: begin
						// nop and the spare code leave everything alone
						flush <= 1'b0;
					end
				endcase
			end
		end
	end

endmodule

//--- smooth_top.sv
// sample smoothing channel
`timescale 1ns/1ps
`include "filt_config.svh"

module smooth_top (
	input  logic                clk,
	input  logic                rst_n,
	// command port
	input  logic                cmd_valid,
	input  ctrl_pkg::cmd_op_e   cmd_op,
	input  ctrl_pkg::cmd_arg_t  cmd_arg,
	// sample port
	input  logic                sample_valid,
	input  filt_pkg::sample_t   sample,
	// status and result
	output filt_pkg::avg_mode_e mode,
	output logic                out_valid,
	output filt_pkg::sample_t   avg_out,
	output logic                settled
);
	import filt_pkg::*;

	// controller to tap line
	logic    flush;

	// tap line to engine
	sample_t taps [`WIN_DEPTH];
	fill_t   fill;
	logic    window_valid;

	// command decode, mode also goes out for readback
	smooth_ctrl u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_arg   (cmd_arg),
		.mode      (mode),
		.flush     (flush)
	);

	// history of the last sixteen samples
	sample_window u_window (
		.clk          (clk),
		.rst_n        (rst_n),
		.sample_valid (sample_valid),
		.sample       (sample),
		.flush        (flush),
		.taps         (taps),
		.fill         (fill),
		.window_valid (window_valid)
	);

	// two stage sum and scale
	// result two edges after the shift edge
	avg_engine u_engine (
		.clk          (clk),
		.rst_n        (rst_n),
		.window_valid (window_valid),
		.taps         (taps),
		.fill         (fill),
		.mode         (mode),
		.out_valid    (out_valid),
		.avg_out      (avg_out),
		.settled      (settled)
	);

endmodule

//--- tb_smooth.sv
// smoothing channel testbench
`timescale 1ns/1ps
`include "filt_config.svh"

module tb_smooth;
	import filt_pkg::*;
	import ctrl_pkg::*;

	// test lengths
	localparam int N_RAND    = 40;
	localparam int N_BURST   = 12;
	localparam int N_EXTREME = 20;
	localparam int CMD_CYC   = 6;
	localparam int DRAIN     = 6;

	// upper bound on stimulus cycles, summed per test
	localparam int STIM_CYCLES = 6 + 9 * CMD_CYC
		+ 5 * (CMD_CYC + N_RAND + DRAIN)
		+ (CMD_CYC + N_BURST * 7 + DRAIN)
		+ (CMD_CYC + 24 + DRAIN)
		+ 4 * (CMD_CYC + DRAIN) + 26
		+ 2 * (CMD_CYC + N_EXTREME + DRAIN);
	localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 100;

	// full-scale sample values
	localparam sample_t MAX_POS = sample_t'({1'b0, {(`SAMPLE_W-1){1'b1}}});
	localparam sample_t MIN_NEG = sample_t'({1'b1, {(`SAMPLE_W-1){1'b0}}});

	// DUT ports
	logic      clk;
	logic      rst_n;
	logic      cmd_valid;
	cmd_op_e   cmd_op;
	cmd_arg_t  cmd_arg;
	logic      sample_valid;
	sample_t   sample;
	avg_mode_e mode;
	logic      out_valid;
	sample_t   avg_out;
	logic      settled;

	// run bookkeeping
	int        cycle = 0;
	int        n_sent = 0;
	int        n_recv = 0;
	string     test_name = "reset";

	// reference model state, newest sample at the front
	sample_t   hist [$];
	int        model_fill;
	avg_mode_e model_mode;

	// expected results in output order
	sample_t   exp_avg [$];
	logic      exp_settled [$];
	int        exp_cycle [$];

	smooth_top dut0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.cmd_valid    (cmd_valid),
		.cmd_op       (cmd_op),
		.cmd_arg      (cmd_arg),
		.sample_valid (sample_valid),
		.sample       (sample),
		.mode         (mode),
		.out_valid    (out_valid),
		.avg_out      (avg_out),
		.settled      (settled)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "run stopped on error");
	endtask

	// cycle count plus run limit
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			fail_run("timeout: run did not finish within the cycle limit");
		end
	end

	task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
		if (actual !== expected) begin
			fail_run($sformatf("FAIL %s: expected %0d, actual %0d", name, expected, actual));
		end
	endtask

	task automatic check_mode(input string name, input avg_mode_e expected,
			input avg_mode_e actual);
		if (actual !== expected) begin
			fail_run($sformatf("FAIL %s: expected %s, actual %s", name, expected.name(),
				actual.name()));
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			fail_run($sformatf("FAIL %s: expected %b, actual %b", name, expected, actual));
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			fail_run($sformatf("FAIL %s: expected %0d, actual %0d", name, expected, actual));
		end
	endtask

	// taps averaged by each window length
	function automatic int window_len(input avg_mode_e m);
		case (m)
			AVG2:    return 2;
			AVG3:    return 3;
			AVG4:    return 4;
			AVG8:    return 8;
			default: return 16;
		endcase
	endfunction

	// command argument code to mode, 4 and up mean sixteen taps
	function automatic avg_mode_e mode_for_code(input int code);
		case (code)
			0:       return AVG2;
			1:       return AVG3;
			2:       return AVG4;
			3:       return AVG8;
			default: return AVG16;
		endcase
	endfunction

	// reference average
	// missing history counts as zero
	function automatic sample_t expected_avg(input sample_t h [$], input avg_mode_e m);
		longint total;
		longint divisor;
		longint q;
		total   = '0;
		divisor = longint'(window_len(m));
		for (int i = 0; i < window_len(m); i++) begin
			if (i < h.size()) begin
				total += longint'(h[i]);
			end
		end
		if (m == AVG3) begin
			// truncation toward zero
			q = total / longint'(3);
		end else if (total >= longint'(0)) begin
			q = total / divisor;
		end else begin
			// floor for negative sums
			q = -((-total + divisor - longint'(1)) / divisor);
		end
		return sample_t'(q);
	endfunction

	// all inputs quiet for n cycles
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			cmd_valid    = 1'b0;
			sample_valid = 1'b0;
		end
	endtask

	// one sample, model updated on the same cycle
	task automatic send_sample(input sample_t s);
		@(posedge clk);
		#1;
		cmd_valid    = 1'b0;
		sample_valid = 1'b1;
		sample       = s;
		hist.push_front(s);
		if (hist.size() > `WIN_DEPTH) begin
			hist.delete(`WIN_DEPTH);
		end
		if (model_fill < `WIN_DEPTH) begin
			model_fill++;
		end
		exp_avg.push_back(expected_avg(hist, model_mode));
		exp_settled.push_back(model_fill >= window_len(model_mode));
		// taken on the next edge, result two edges later
		exp_cycle.push_back(cycle + 3);
		n_sent++;
	endtask

	// wait until every sent sample has its result
	task automatic wait_idle();
		idle_cycles(1);
		while (n_recv < n_sent) begin
			idle_cycles(1);
		end
	endtask

	// one command, then three quiet cycles
	task automatic send_cmd(input cmd_op_e op, input cmd_arg_t arg);
		@(posedge clk);
		#1;
		sample_valid = 1'b0;
		cmd_valid    = 1'b1;
		cmd_op       = op;
		cmd_arg      = arg;
		if (op == CMD_SET_MODE) begin
			model_mode = mode_for_code(int'(arg));
		end
		// set-mode and clear both empty the history
		if (op == CMD_SET_MODE || op == CMD_CLEAR) begin
			hist.delete();
			model_fill = 0;
		end
		idle_cycles(3);
	endtask

	// compare each result against the next expected one
	always @(negedge clk) begin
		if (rst_n && out_valid) begin
			if (n_recv >= exp_avg.size()) begin
				fail_run("out_valid pulsed with no sample waiting for a result");
			end else begin
				check_count({test_name, " latency"}, exp_cycle[n_recv], cycle);
				check_sample({test_name, " avg_out"}, exp_avg[n_recv], avg_out);
				check_flag({test_name, " settled"}, exp_settled[n_recv], settled);
				n_recv++;
			end
		end
	end

	task automatic test_mode_readback();
		test_name = "mode readback";
		for (int code = 0; code < 8; code++) begin
			send_cmd(CMD_SET_MODE, cmd_arg_t'(code));
			check_mode($sformatf("mode readback code %0d", code), mode_for_code(code), mode);
		end
	endtask

	// back-to-back random samples in every mode
	task automatic test_all_modes();
		for (int code = 0; code < 5; code++) begin
			test_name = $sformatf("random stream code %0d", code);
			send_cmd(CMD_SET_MODE, cmd_arg_t'(code));
			repeat (N_RAND) begin
				send_sample(sample_t'($urandom));
			end
			wait_idle();
		end
	endtask

	// sparse bursts with gaps
	task automatic test_bursts();
		int burst;
		int gap;
		test_name = "sparse bursts";
		send_cmd(CMD_SET_MODE, cmd_arg_t'(2));
		repeat (N_BURST) begin
			burst = int'($urandom_range(4, 1));
			gap   = int'($urandom_range(3, 1));
			repeat (burst) begin
				send_sample(sample_t'($urandom));
			end
			idle_cycles(gap);
		end
		wait_idle();
	endtask

	// settled goes high on the eighth sample
	task automatic test_settled();
		test_name = "settled after flush";
		send_cmd(CMD_SET_MODE, cmd_arg_t'(3));
		repeat (12) begin
			send_sample(sample_t'($urandom));
			idle_cycles(1);
		end
		wait_idle();
	endtask

	// flushes in the middle of a stream
	task automatic test_flush();
		test_name = "flush by command";
		send_cmd(CMD_SET_MODE, cmd_arg_t'(2));
		repeat (10) send_sample(sample_t'($urandom));
		wait_idle();
		send_cmd(CMD_CLEAR, cmd_arg_t'(0));
		check_mode("flush clear keeps mode", AVG4, mode);
		repeat (6) send_sample(sample_t'($urandom));
		wait_idle();
		send_cmd(CMD_SET_MODE, cmd_arg_t'(1));
		repeat (5) send_sample(sample_t'($urandom));
		wait_idle();
		// nop keeps both mode and history
		send_cmd(CMD_NOP, cmd_arg_t'(4));
		check_mode("flush nop keeps mode", AVG3, mode);
		repeat (5) send_sample(sample_t'($urandom));
		wait_idle();
	endtask

	// full-scale runs in sixteen-tap mode
	task automatic test_extremes();
		test_name = "full scale";
		send_cmd(CMD_SET_MODE, cmd_arg_t'(4));
		repeat (N_EXTREME) send_sample(MAX_POS);
		wait_idle();
		check_sample("full scale positive", MAX_POS, avg_out);
		send_cmd(CMD_CLEAR, cmd_arg_t'(0));
		repeat (N_EXTREME) send_sample(MIN_NEG);
		wait_idle();
		check_sample("full scale negative", MIN_NEG, avg_out);
	endtask

	initial begin
		void'($urandom(32'h8b7d_f6b1));
		rst_n        = 1'b0;
		cmd_valid    = 1'b0;
		cmd_op       = CMD_NOP;
		cmd_arg      = '0;
		sample_valid = 1'b0;
		sample       = '0;
		model_mode   = AVG2;
		model_fill   = 0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		idle_cycles(1);
		check_mode("reset mode", AVG2, mode);
		check_flag("reset out_valid", 1'b0, out_valid);
		check_flag("reset settled", 1'b0, settled);

		test_mode_readback();
		test_all_modes();
		test_bursts();
		test_settled();
		test_flush();
		test_extremes();

		// quiet window, a stray out_valid still reaches the comparator
		idle_cycles(DRAIN);
		test_name = "end of run";
		if (n_recv != exp_avg.size()) begin
			fail_run("expected results were left with no matching out_valid");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule
